// File: hdl/avb_pkg.sv
// AVMM side constants; single 32-bit words only, byte addresses, no burstcount signal on the bus

package avb_pkg;

	//////////////////////////////////////////////////
	// Channel bus widths
	//////////////////////////////////////////////////
	localparam int AVMM_ADDR_W = 17;              // Byte address
	localparam int AVMM_DATA_W = 32;
	localparam int AVMM_BE_W   = AVMM_DATA_W / 8;
	localparam int BURST_W     = 8;               // Burst length in words
	localparam int REG_ADDR_W  = 16;              // Buffer select toward the SPI registers

	// Bridge sequencer states
	typedef enum logic [3:0] {
		idle         = 4'h0,
		cmd          = 4'h1,
		wr_rdspireg  = 4'h2,
		wr_waitreq   = 4'h3,
		wr_setnext   = 4'h4,
		wr_endwr     = 4'h5,
		rd_avbchnl   = 4'h6,
		rd_waitrdvld = 4'h7,
		rd_setnext   = 4'h8,
		rd_endrd     = 4'h9
	} avb_state_e;

endpackage

// File: hdl/spis_reg_pkg.sv
// Host register map of the SPI slave; 16-bit host addresses, buffers are 64 words deep

package spis_reg_pkg;

	//////////////////////////////////////////////////
	// Host addresses
	//////////////////////////////////////////////////
	localparam logic [15:0] REG_CMD    = 16'h0000;
	localparam logic [15:0] REG_OFFSET = 16'h0004;
	localparam logic [15:0] REG_STATUS = 16'h0008;
	localparam logic [15:0] WRBUF_BASE = 16'h0200; // Push port, also bridge write select
	localparam logic [15:0] RDBUF_BASE = 16'h1000; // Pop port, also bridge read select

	localparam int BUF_DEPTH = 64;
	localparam int BUF_AW    = $clog2(BUF_DEPTH);

	// Field positions
	localparam int CMD_SEL_LSB    = 8;
	localparam int CMD_RDNWR_BIT  = 10;
	localparam int CMD_START_BIT  = 31;
	localparam int STAT_BUSY_BIT  = 0;
	localparam int STAT_DONE_BIT  = 1;
	localparam int STAT_WRLVL_LSB = 8;
	localparam int STAT_RDLVL_LSB = 16;

	typedef enum logic [1:0] {chnl0 = 2'd0, chnl1 = 2'd1, chnl2 = 2'd2} avmm_chnl_e;

endpackage

// File: hdl/spis_avb_bridge.sv
// One read outstanding at a time, full byte enables only; select value 3 goes to channel 0
`timescale 1ns/10ps

module spis_avb_bridge (
	input  logic                              s_avmm_clk,
	input  logic                              s_avmm_rst_n,

	// Command from the register block
	input  logic [avb_pkg::BURST_W-1:0]       avmm_brstlen,
	input  spis_reg_pkg::avmm_chnl_e          avmm_sel,
	input  logic [avb_pkg::AVMM_ADDR_W-1:0]   avmm_offset,
	input  logic                              avmm_transvld,
	input  logic                              avmm_rdnwr,
	input  logic [avb_pkg::AVMM_DATA_W-1:0]   reg2avb_wdata,

	// Buffer side
	output logic [avb_pkg::REG_ADDR_W-1:0]    avb2reg_addr,
	output logic [avb_pkg::AVMM_DATA_W-1:0]   avb2reg_rdata_q,
	output logic                              avb2reg_read_pulse,
	output logic                              avb2reg_write,
	output logic                              avmmtransvld_up,

	// AVMM channel 0
	output logic [avb_pkg::AVMM_ADDR_W-1:0]   s_avmm0_addr,
	output logic [avb_pkg::AVMM_BE_W-1:0]     s_avmm0_byte_en,
	output logic                              s_avmm0_write,
	output logic                              s_avmm0_read,
	output logic [avb_pkg::AVMM_DATA_W-1:0]   s_avmm0_wdata,
	input  logic [avb_pkg::AVMM_DATA_W-1:0]   s_avmm0_rdata,
	input  logic                              s_avmm0_rdatavld,
	input  logic                              s_avmm0_waitreq,

	// AVMM channel 1
	output logic [avb_pkg::AVMM_ADDR_W-1:0]   s_avmm1_addr,
	output logic [avb_pkg::AVMM_BE_W-1:0]     s_avmm1_byte_en,
	output logic                              s_avmm1_write,
	output logic                              s_avmm1_read,
	output logic [avb_pkg::AVMM_DATA_W-1:0]   s_avmm1_wdata,
	input  logic [avb_pkg::AVMM_DATA_W-1:0]   s_avmm1_rdata,
	input  logic                              s_avmm1_rdatavld,
	input  logic                              s_avmm1_waitreq,

	// AVMM channel 2
	output logic [avb_pkg::AVMM_ADDR_W-1:0]   s_avmm2_addr,
	output logic [avb_pkg::AVMM_BE_W-1:0]     s_avmm2_byte_en,
	output logic                              s_avmm2_write,
	output logic                              s_avmm2_read,
	output logic [avb_pkg::AVMM_DATA_W-1:0]   s_avmm2_wdata,
	input  logic [avb_pkg::AVMM_DATA_W-1:0]   s_avmm2_rdata,
	input  logic                              s_avmm2_rdatavld,
	input  logic                              s_avmm2_waitreq
);
	import avb_pkg::*;
	import spis_reg_pkg::*;

	avb_state_e             cur_st;
	avb_state_e             nxt_st;
	logic                   transvld_d1;
	logic                   transvld_pulse;
	logic                   buf_read;        // Write buffer read level
	logic                   buf_read_d1;
	logic [BURST_W-1:0]     burstcount;      // Beats left after the current one
	logic [AVMM_ADDR_W-1:0] avmm_addr;
	logic [AVMM_ADDR_W-1:0] avmm_addr_d1;
	logic [AVMM_DATA_W-1:0] avmm_wdata;
	logic                   avmm_write;
	logic                   avmm_read;
	logic [AVMM_DATA_W-1:0] chnl_rdata;
	logic                   chnl_rdatavld;
	logic                   chnl_waitreq;

	//////////////////////////////////////////////////
	// Start edge and pop pulse
	//////////////////////////////////////////////////
	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n) begin
			transvld_d1 <= 1'b0;
			buf_read_d1 <= 1'b0;
		end else begin
			transvld_d1 <= avmm_transvld;
			buf_read_d1 <= buf_read;
		end
	end

	assign transvld_pulse     = avmm_transvld & ~transvld_d1;
	assign buf_read           = (cur_st == wr_rdspireg) || (cur_st == wr_waitreq);
	assign avb2reg_read_pulse = buf_read & ~buf_read_d1; // One pop per write beat

	//////////////////////////////////////////////////
	// Beat counter, address and buffer select
	//////////////////////////////////////////////////
	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n) begin
			burstcount   <= '0;
			avmm_addr    <= '0;
			avb2reg_addr <= '0;
		end else begin
			case (cur_st)
				idle: begin
					burstcount   <= '0;
					avmm_addr    <= '0;
					avb2reg_addr <= '0;
				end
				cmd: begin
					burstcount   <= avmm_brstlen - 1'b1;
					avmm_addr    <= avmm_offset;
					avb2reg_addr <= avmm_rdnwr ? RDBUF_BASE : WRBUF_BASE;
				end
				wr_setnext, rd_setnext: begin
					if (burstcount != '0) begin
						burstcount <= burstcount - 1'b1;
						avmm_addr  <= avmm_addr + AVMM_ADDR_W'(4); // Next word
					end
				end
				default: ;
			endcase
		end
	end

	// Lags the counter so the bus address never moves under a strobe
	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n)
			avmm_addr_d1 <= '0;
		else
			avmm_addr_d1 <= avmm_addr;
	end

	always_ff @(posedge s_avmm_clk) begin
		if (cur_st == wr_rdspireg)
			avmm_wdata <= reg2avb_wdata; // Head word, popped on this same edge
	end

	assign avmm_write      = (cur_st == wr_waitreq);
	assign avmm_read       = (cur_st == rd_waitrdvld);
	assign avb2reg_write   = avmm_read & chnl_rdatavld;
	assign avb2reg_rdata_q = chnl_rdata;
	assign avmmtransvld_up = (cur_st == wr_endwr) || (cur_st == rd_endrd);

	//////////////////////////////////////////////////
	// Channel multiplexer
	//////////////////////////////////////////////////
	always_comb begin
		s_avmm0_addr    = '0;
		s_avmm0_byte_en = '0;
		s_avmm0_write   = 1'b0;
		s_avmm0_read    = 1'b0;
		s_avmm0_wdata   = '0;
		s_avmm1_addr    = '0;
		s_avmm1_byte_en = '0;
		s_avmm1_write   = 1'b0;
		s_avmm1_read    = 1'b0;
		s_avmm1_wdata   = '0;
		s_avmm2_addr    = '0;
		s_avmm2_byte_en = '0;
		s_avmm2_write   = 1'b0;
		s_avmm2_read    = 1'b0;
		s_avmm2_wdata   = '0;
		case (avmm_sel)
			chnl1: begin
				s_avmm1_addr    = avmm_addr_d1;
				s_avmm1_byte_en = '1;
				s_avmm1_write   = avmm_write;
				s_avmm1_read    = avmm_read;
				s_avmm1_wdata   = avmm_wdata;
			end
			chnl2: begin
				s_avmm2_addr    = avmm_addr_d1;
				s_avmm2_byte_en = '1;
				s_avmm2_write   = avmm_write;
				s_avmm2_read    = avmm_read;
				s_avmm2_wdata   = avmm_wdata;
			end
			default: begin // Channel 0 and the unused code
				s_avmm0_addr    = avmm_addr_d1;
				s_avmm0_byte_en = '1;
				s_avmm0_write   = avmm_write;
				s_avmm0_read    = avmm_read;
				s_avmm0_wdata   = avmm_wdata;
			end
		endcase
	end

	// Return path from the selected channel
	always_comb begin
		case (avmm_sel)
			chnl1: begin
				chnl_rdata    = s_avmm1_rdata;
				chnl_rdatavld = s_avmm1_rdatavld;
				chnl_waitreq  = s_avmm1_waitreq;
			end
			chnl2: begin
				chnl_rdata    = s_avmm2_rdata;
				chnl_rdatavld = s_avmm2_rdatavld;
				chnl_waitreq  = s_avmm2_waitreq;
			end
			default: begin
				chnl_rdata    = s_avmm0_rdata;
				chnl_rdatavld = s_avmm0_rdatavld;
				chnl_waitreq  = s_avmm0_waitreq;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////
	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n)
			cur_st <= idle;
		else
			cur_st <= nxt_st;
	end

	always_comb begin
		case (cur_st)
			idle:         nxt_st = transvld_pulse ? cmd : idle;
			cmd:          nxt_st = avmm_rdnwr ? rd_avbchnl : wr_rdspireg;
			wr_rdspireg:  nxt_st = wr_waitreq;
			wr_waitreq:   nxt_st = chnl_waitreq ? wr_waitreq : wr_setnext; // Hold under back-pressure
			wr_setnext:   nxt_st = (burstcount == '0) ? wr_endwr : wr_rdspireg;
			wr_endwr:     nxt_st = idle;
			rd_avbchnl:   nxt_st = rd_waitrdvld;
			rd_waitrdvld: nxt_st = chnl_rdatavld ? rd_setnext : rd_waitrdvld;
			rd_setnext:   nxt_st = (burstcount == '0) ? rd_endrd : rd_avbchnl;
			rd_endrd:     nxt_st = idle;
			default:      nxt_st = idle;
		endcase
	end

endmodule

// File: hdl/spis_buf_regs.sv
// REG_CMD must not be rewritten while busy; pushes to a full buffer and pops from an empty one are dropped
`timescale 1ns/10ps

module spis_buf_regs (
	input  logic                              s_avmm_clk,
	input  logic                              s_avmm_rst_n,

	// Host port
	input  logic [avb_pkg::REG_ADDR_W-1:0]    host_addr,
	input  logic [avb_pkg::AVMM_DATA_W-1:0]   host_wdata,
	input  logic                              host_write,
	input  logic                              host_read,
	output logic [avb_pkg::AVMM_DATA_W-1:0]   host_rdata,

	// From the bridge
	input  logic [avb_pkg::REG_ADDR_W-1:0]    avb2reg_addr,
	input  logic                              avb2reg_read_pulse,
	input  logic                              avb2reg_write,
	input  logic [avb_pkg::AVMM_DATA_W-1:0]   avb2reg_rdata_q,
	input  logic                              avmmtransvld_up,

	// To the bridge
	output logic [avb_pkg::BURST_W-1:0]       avmm_brstlen,
	output spis_reg_pkg::avmm_chnl_e          avmm_sel,
	output logic [avb_pkg::AVMM_ADDR_W-1:0]   avmm_offset,
	output logic                              avmm_rdnwr,
	output logic                              avmm_transvld,
	output logic [avb_pkg::AVMM_DATA_W-1:0]   reg2avb_wdata
);
	import avb_pkg::*;
	import spis_reg_pkg::*;

	logic                   busy;
	logic                   done;
	logic [AVMM_DATA_W-1:0] rd_word;

	// Index 0 is the write buffer, index 1 the read buffer
	logic                   buf_push [2];
	logic                   buf_pop  [2];
	logic [AVMM_DATA_W-1:0] buf_din  [2];
	logic [AVMM_DATA_W-1:0] buf_head [2];
	logic [BUF_AW:0]        buf_lvl  [2];

	//////////////////////////////////////////////////
	// Command, offset and status
	//////////////////////////////////////////////////
	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n) begin
			avmm_brstlen  <= '0;
			avmm_sel      <= chnl0;
			avmm_rdnwr    <= 1'b0;
			avmm_transvld <= 1'b0;
			avmm_offset   <= '0;
			busy          <= 1'b0;
			done          <= 1'b0;
		end else begin
			if (host_write && (host_addr == REG_CMD)) begin
				avmm_brstlen  <= host_wdata[BURST_W-1:0];
				avmm_sel      <= avmm_chnl_e'(host_wdata[CMD_SEL_LSB +: $bits(avmm_chnl_e)]);
				avmm_rdnwr    <= host_wdata[CMD_RDNWR_BIT];
				avmm_transvld <= host_wdata[CMD_START_BIT];
				busy          <= host_wdata[CMD_START_BIT];
				done          <= 1'b0; // New command clears done
			end
			if (host_write && (host_addr == REG_OFFSET))
				avmm_offset <= host_wdata[AVMM_ADDR_W-1:0];
			if (avmmtransvld_up) begin // Burst finished
				avmm_transvld <= 1'b0;
				busy          <= 1'b0;
				done          <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Buffer strobes
	//////////////////////////////////////////////////
	assign buf_push[0] = host_write && (host_addr == WRBUF_BASE);
	assign buf_din[0]  = host_wdata;
	assign buf_pop[0]  = avb2reg_read_pulse && (avb2reg_addr == WRBUF_BASE);

	assign buf_push[1] = avb2reg_write && (avb2reg_addr == RDBUF_BASE);
	assign buf_din[1]  = avb2reg_rdata_q;
	assign buf_pop[1]  = host_read && (host_addr == RDBUF_BASE);

	assign reg2avb_wdata = buf_head[0]; // Valid while the write buffer is non-empty

	for (genvar i = 0; i < 2; i++) begin : g_buf
		logic [AVMM_DATA_W-1:0] mem [BUF_DEPTH];
		logic [BUF_AW-1:0]      wr_ptr;
		logic [BUF_AW-1:0]      rd_ptr;
		logic [BUF_AW:0]        lvl;
		logic                   push_ok;
		logic                   pop_ok;

		assign push_ok = buf_push[i] && (lvl < BUF_DEPTH);
		assign pop_ok  = buf_pop[i] && (lvl != '0);

		always_ff @(posedge s_avmm_clk) begin
			if (push_ok)
				mem[wr_ptr] <= buf_din[i];
		end

		always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
			if (!s_avmm_rst_n) begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				lvl    <= '0;
			end else begin
				if (push_ok)
					wr_ptr <= wr_ptr + 1'b1;
				if (pop_ok)
					rd_ptr <= rd_ptr + 1'b1;
				case ({push_ok, pop_ok})
					2'b10:   lvl <= lvl + 1'b1;
					2'b01:   lvl <= lvl - 1'b1;
					default: ;
				endcase
			end
		end

		assign buf_head[i] = mem[rd_ptr];
		assign buf_lvl[i]  = lvl;
	end

	//////////////////////////////////////////////////
	// Host read data
	//////////////////////////////////////////////////
	always_comb begin
		rd_word = '0;
		case (host_addr)
			REG_CMD: begin
				rd_word[BURST_W-1:0]                          = avmm_brstlen;
				rd_word[CMD_SEL_LSB +: $bits(avmm_chnl_e)]    = avmm_sel;
				rd_word[CMD_RDNWR_BIT]                        = avmm_rdnwr;
				rd_word[CMD_START_BIT]                        = avmm_transvld;
			end
			REG_OFFSET: rd_word[AVMM_ADDR_W-1:0] = avmm_offset;
			REG_STATUS: begin
				rd_word[STAT_BUSY_BIT]       = busy;
				rd_word[STAT_DONE_BIT]       = done;
				rd_word[STAT_WRLVL_LSB +: 8] = 8'(buf_lvl[0]);
				rd_word[STAT_RDLVL_LSB +: 8] = 8'(buf_lvl[1]);
			end
			RDBUF_BASE: rd_word = buf_head[1];
			default: ;
		endcase
	end

	always_ff @(posedge s_avmm_clk) begin
		if (host_read)
			host_rdata <= rd_word; // Valid the cycle after the strobe
	end

endmodule

// File: hdl/spis_avb_top.sv
// SPI shifter not included; the host port stands in for it and drives one strobe per cycle
`timescale 1ns/10ps

module spis_avb_top (
	input  logic                              s_avmm_clk,
	input  logic                              s_avmm_rst_n,

	// Host port
	input  logic [avb_pkg::REG_ADDR_W-1:0]    host_addr,
	input  logic [avb_pkg::AVMM_DATA_W-1:0]   host_wdata,
	input  logic                              host_write,
	input  logic                              host_read,
	output logic [avb_pkg::AVMM_DATA_W-1:0]   host_rdata,

	output logic [avb_pkg::AVMM_ADDR_W-1:0]   s_avmm0_addr,
	output logic [avb_pkg::AVMM_BE_W-1:0]     s_avmm0_byte_en,
	output logic                              s_avmm0_write,
	output logic                              s_avmm0_read,
	output logic [avb_pkg::AVMM_DATA_W-1:0]   s_avmm0_wdata,
	input  logic [avb_pkg::AVMM_DATA_W-1:0]   s_avmm0_rdata,
	input  logic                              s_avmm0_rdatavld,
	input  logic                              s_avmm0_waitreq,

	output logic [avb_pkg::AVMM_ADDR_W-1:0]   s_avmm1_addr,
	output logic [avb_pkg::AVMM_BE_W-1:0]     s_avmm1_byte_en,
	output logic                              s_avmm1_write,
	output logic                              s_avmm1_read,
	output logic [avb_pkg::AVMM_DATA_W-1:0]   s_avmm1_wdata,
	input  logic [avb_pkg::AVMM_DATA_W-1:0]   s_avmm1_rdata,
	input  logic                              s_avmm1_rdatavld,
	input  logic                              s_avmm1_waitreq,

	output logic [avb_pkg::AVMM_ADDR_W-1:0]   s_avmm2_addr,
	output logic [avb_pkg::AVMM_BE_W-1:0]     s_avmm2_byte_en,
	output logic                              s_avmm2_write,
	output logic                              s_avmm2_read,
	output logic [avb_pkg::AVMM_DATA_W-1:0]   s_avmm2_wdata,
	input  logic [avb_pkg::AVMM_DATA_W-1:0]   s_avmm2_rdata,
	input  logic                              s_avmm2_rdatavld,
	input  logic                              s_avmm2_waitreq
);
	import avb_pkg::*;
	import spis_reg_pkg::*;

	// Register block to bridge
	logic [BURST_W-1:0]     avmm_brstlen;
	avmm_chnl_e             avmm_sel;
	logic [AVMM_ADDR_W-1:0] avmm_offset;
	logic                   avmm_rdnwr;
	logic                   avmm_transvld;   // Level, held until the burst ends
	logic [AVMM_DATA_W-1:0] reg2avb_wdata;

	// Bridge to register block
	logic [REG_ADDR_W-1:0]  avb2reg_addr;
	logic [AVMM_DATA_W-1:0] avb2reg_rdata_q;
	logic                   avb2reg_read_pulse;
	logic                   avb2reg_write;
	logic                   avmmtransvld_up;

	spis_buf_regs u_regs (.*);

	spis_avb_bridge u_bridge (.*);

endmodule

// File: testbench/tb_clk_gen.sv
// Free-running 4 ns clock; reset held low for the first 4 rising edges, released 1 ns after
`timescale 1ns/10ps

module tb_clk_gen (
	output logic s_avmm_clk,
	output logic s_avmm_rst_n
);
	initial begin
		s_avmm_clk = 1'b0;
		forever #2 s_avmm_clk = ~s_avmm_clk;
	end

	initial begin
		s_avmm_rst_n = 1'b0;
		repeat (4) @(posedge s_avmm_clk);
		#1;
		s_avmm_rst_n = 1'b1; // Off the edge, like the other stimulus
	end
endmodule

// File: testbench/spis_avb_assert.sv
// Bound into spis_avb_bridge; the three channels are folded into one view, valid since idle ones sit at zero
`timescale 1ns/10ps

module spis_avb_assert (
	input logic                            s_avmm_clk,
	input logic                            s_avmm_rst_n,
	input logic [2:0]                      ch_write,      // One bit per channel
	input logic [2:0]                      ch_read,
	input logic [avb_pkg::AVMM_ADDR_W-1:0] ch_addr,       // OR of all channel addresses
	input logic [avb_pkg::AVMM_DATA_W-1:0] ch_wdata,
	input logic                            stalled,       // A write seen with waitreq high
	input logic                            avmmtransvld_up
);
	a_no_wr_and_rd: assert property (@(posedge s_avmm_clk) disable iff (!s_avmm_rst_n)
		(ch_write & ch_read) == 3'b000)
		else $error("write and read high together on one channel");

	a_one_chnl: assert property (@(posedge s_avmm_clk) disable iff (!s_avmm_rst_n)
		$onehot0(ch_write | ch_read))
		else $error("more than one channel active");

	// Back-pressure holds the whole write
	a_wr_hold: assert property (@(posedge s_avmm_clk) disable iff (!s_avmm_rst_n)
		stalled |=> ((ch_write != 3'b000) && $stable(ch_write) && $stable(ch_addr)
			&& $stable(ch_wdata)))
		else $error("write address or data moved under waitreq");

	a_up_pulse: assert property (@(posedge s_avmm_clk) disable iff (!s_avmm_rst_n)
		avmmtransvld_up |=> !avmmtransvld_up)
		else $error("avmmtransvld_up longer than one cycle");
endmodule

bind spis_avb_bridge spis_avb_assert u_assert (
	.s_avmm_clk      (s_avmm_clk),
	.s_avmm_rst_n    (s_avmm_rst_n),
	.ch_write        ({s_avmm2_write, s_avmm1_write, s_avmm0_write}),
	.ch_read         ({s_avmm2_read, s_avmm1_read, s_avmm0_read}),
	.ch_addr         (s_avmm0_addr | s_avmm1_addr | s_avmm2_addr),
	.ch_wdata        (s_avmm0_wdata | s_avmm1_wdata | s_avmm2_wdata),
	.stalled         ((s_avmm0_write & s_avmm0_waitreq) | (s_avmm1_write & s_avmm1_waitreq)
		| (s_avmm2_write & s_avmm2_waitreq)),
	.avmmtransvld_up (avmmtransvld_up)
);

// File: testbench/tb_spis_avb.sv
// Random bursts of 1 to 16 words from a fixed seed; offsets stay in the low 512 bytes of each channel
`timescale 1ns/10ps

module tb_spis_avb;
	import avb_pkg::*;
	import spis_reg_pkg::*;

	localparam int MAX_POLL = 1000;   // Status polls before giving up on done
	localparam int N_RAND   = 50;

	logic                   s_avmm_clk;
	logic                   s_avmm_rst_n;
	logic [REG_ADDR_W-1:0]  host_addr;
	logic [AVMM_DATA_W-1:0] host_wdata;
	logic                   host_write;
	logic                   host_read;
	logic [AVMM_DATA_W-1:0] host_rdata;

	// Channel side, indexed by channel number
	logic [AVMM_ADDR_W-1:0] ch_addr     [3];
	logic [AVMM_BE_W-1:0]   ch_be       [3];
	logic                   ch_write    [3];
	logic                   ch_read     [3];
	logic [AVMM_DATA_W-1:0] ch_wdata    [3];
	logic [AVMM_DATA_W-1:0] ch_rdata    [3];
	logic                   ch_rdatavld [3];
	logic                   ch_waitreq  [3];

	// Sparse memories, key holds channel and byte address
	logic [AVMM_DATA_W-1:0] tgt_mem [int];
	logic [AVMM_DATA_W-1:0] ref_mem [int];

	// Transfers as the targets saw them
	int                     wr_log_ch   [$];
	logic [AVMM_ADDR_W-1:0] wr_log_addr [$];
	logic [AVMM_DATA_W-1:0] wr_log_data [$];
	int                     rd_log_ch   [$];
	logic [AVMM_ADDR_W-1:0] rd_log_addr [$];

	int active_ch = -1;  // Channel of the running burst, -1 when idle
	int val_errs  = 0;
	int misc_errs = 0;
	bit timed_out = 1'b0;

	tb_clk_gen u_clk_gen (
		.s_avmm_clk   (s_avmm_clk),
		.s_avmm_rst_n (s_avmm_rst_n)
	);

	spis_avb_top u_dut (
		.s_avmm_clk       (s_avmm_clk),
		.s_avmm_rst_n     (s_avmm_rst_n),
		.host_addr        (host_addr),
		.host_wdata       (host_wdata),
		.host_write       (host_write),
		.host_read        (host_read),
		.host_rdata       (host_rdata),
		.s_avmm0_addr     (ch_addr[0]),
		.s_avmm0_byte_en  (ch_be[0]),
		.s_avmm0_write    (ch_write[0]),
		.s_avmm0_read     (ch_read[0]),
		.s_avmm0_wdata    (ch_wdata[0]),
		.s_avmm0_rdata    (ch_rdata[0]),
		.s_avmm0_rdatavld (ch_rdatavld[0]),
		.s_avmm0_waitreq  (ch_waitreq[0]),
		.s_avmm1_addr     (ch_addr[1]),
		.s_avmm1_byte_en  (ch_be[1]),
		.s_avmm1_write    (ch_write[1]),
		.s_avmm1_read     (ch_read[1]),
		.s_avmm1_wdata    (ch_wdata[1]),
		.s_avmm1_rdata    (ch_rdata[1]),
		.s_avmm1_rdatavld (ch_rdatavld[1]),
		.s_avmm1_waitreq  (ch_waitreq[1]),
		.s_avmm2_addr     (ch_addr[2]),
		.s_avmm2_byte_en  (ch_be[2]),
		.s_avmm2_write    (ch_write[2]),
		.s_avmm2_read     (ch_read[2]),
		.s_avmm2_wdata    (ch_wdata[2]),
		.s_avmm2_rdata    (ch_rdata[2]),
		.s_avmm2_rdatavld (ch_rdatavld[2]),
		.s_avmm2_waitreq  (ch_waitreq[2])
	);

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////
	function automatic int mem_key(input int n, input logic [AVMM_ADDR_W-1:0] addr);
		return (n << AVMM_ADDR_W) | int'(addr);
	endfunction

	// Content of a word never written, spread over channel and address
	function automatic logic [AVMM_DATA_W-1:0] fill_word(input int key);
		return (32'(key) * 32'h9e37_79b1) ^ 32'h0f0f_a5a5;
	endfunction

	function automatic logic [AVMM_DATA_W-1:0] tgt_read(input int key);
		return tgt_mem.exists(key) ? tgt_mem[key] : fill_word(key);
	endfunction

	function automatic logic [AVMM_DATA_W-1:0] model_read(input int key);
		return ref_mem.exists(key) ? ref_mem[key] : fill_word(key);
	endfunction

	task automatic log_mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
		$display("ERROR %s got 0x%h exp 0x%h", sig, got, exp);
		val_errs++;
	endtask

	// Host strobes start and end 1 ns after a rising edge
	task automatic host_wr(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
		host_addr  = addr;
		host_wdata = data;
		host_write = 1'b1;
		@(posedge s_avmm_clk);
		#1;
		host_write = 1'b0;
	endtask

	task automatic host_rd(input logic [REG_ADDR_W-1:0] addr, output logic [31:0] data);
		host_addr = addr;
		host_read = 1'b1;
		@(posedge s_avmm_clk);
		#1;
		host_read = 1'b0;
		data      = host_rdata; // Registered on the edge just passed
	endtask

	task automatic wait_done(output logic [31:0] stat);
		int polls;
		polls = 0;
		stat  = '0;
		while (!stat[STAT_DONE_BIT] && polls < MAX_POLL) begin
			host_rd(REG_STATUS, stat);
			polls++;
		end
		if (!stat[STAT_DONE_BIT]) begin
			$display("Timeout: done was not set within %0d status polls", MAX_POLL);
			misc_errs++;
			timed_out = 1'b1;
		end
	endtask

	//////////////////////////////////////////////////
	// One burst with its reference checks
	//////////////////////////////////////////////////
	task automatic run_burst(input logic rdnwr, input int len, input logic [1:0] sel,
		input logic [AVMM_ADDR_W-1:0] offset);
		logic [AVMM_DATA_W-1:0] words [$];
		logic [31:0]            stat;
		logic [31:0]            got;
		logic [AVMM_ADDR_W-1:0] addr;
		int                     ch;
		int                     key;

		ch = (sel == 2'd3) ? 0 : int'(sel); // Code 3 lands on channel 0
		wr_log_ch.delete();
		wr_log_addr.delete();
		wr_log_data.delete();
		rd_log_ch.delete();
		rd_log_addr.delete();
		if (!rdnwr) begin
			for (int i = 0; i < len; i++) begin
				words.push_back($urandom);
				host_wr(WRBUF_BASE, words[i]);
			end
		end
		host_wr(REG_OFFSET, 32'(offset));
		active_ch = ch;
		host_wr(REG_CMD, {1'b1, 20'd0, rdnwr, sel, 8'(len)});
		host_rd(REG_STATUS, stat);
		if (stat[1:0] !== 2'b01)
			log_mismatch("REG_STATUS[1:0]", 32'(stat[1:0]), 32'h1); // Busy set, done cleared
		wait_done(stat);
		active_ch = -1;
		if (timed_out)
			return;
		if (stat[STAT_BUSY_BIT] !== 1'b0)
			log_mismatch("REG_STATUS busy", 32'(stat[STAT_BUSY_BIT]), 32'h0);
		if (stat[15:8] !== 8'd0)
			log_mismatch("REG_STATUS wrbuf level", 32'(stat[15:8]), 32'h0);

		if (!rdnwr) begin
			if (wr_log_ch.size() != len) begin
				$display("Write burst made %0d writes instead of %0d", wr_log_ch.size(), len);
				misc_errs++;
			end
			for (int i = 0; i < len; i++) begin
				addr = offset + AVMM_ADDR_W'(4 * i);
				key  = mem_key(ch, addr);
				ref_mem[key] = words[i];
				if (i < wr_log_ch.size()) begin
					if (wr_log_ch[i] != ch)
						log_mismatch("write channel", 32'(wr_log_ch[i]), 32'(ch));
					if (wr_log_addr[i] !== addr)
						log_mismatch("s_avmm_addr", 32'(wr_log_addr[i]), 32'(addr));
					if (wr_log_data[i] !== words[i])
						log_mismatch("s_avmm_wdata", wr_log_data[i], words[i]);
				end
			end
		end else begin
			if (stat[23:16] !== 8'(len))
				log_mismatch("REG_STATUS rdbuf level", 32'(stat[23:16]), 32'(len));
			if (rd_log_ch.size() != len) begin
				$display("Read burst made %0d reads instead of %0d", rd_log_ch.size(), len);
				misc_errs++;
			end
			for (int i = 0; i < len; i++) begin
				addr = offset + AVMM_ADDR_W'(4 * i);
				key  = mem_key(ch, addr);
				host_rd(RDBUF_BASE, got);
				if (got !== model_read(key))
					log_mismatch("host_rdata", got, model_read(key));
				if (i < rd_log_ch.size()) begin
					if (rd_log_ch[i] != ch)
						log_mismatch("read channel", 32'(rd_log_ch[i]), 32'(ch));
					if (rd_log_addr[i] !== addr)
						log_mismatch("s_avmm_addr (read)", 32'(rd_log_addr[i]), 32'(addr));
				end
			end
		end
	endtask

	task automatic compare_memories();
		if (tgt_mem.num() != ref_mem.num()) begin
			$display("Targets hold %0d words but the model holds %0d",
				tgt_mem.num(), ref_mem.num());
			misc_errs++;
		end
		foreach (ref_mem[k]) begin
			if (!tgt_mem.exists(k)) begin
				$display("Target %0d never got a write at 0x%05h", k >> AVMM_ADDR_W,
					k & 32'h1_ffff);
				misc_errs++;
			end else if (tgt_mem[k] !== ref_mem[k]) begin
				log_mismatch($sformatf("mem ch%0d 0x%05h", k >> AVMM_ADDR_W, k & 32'h1_ffff),
					tgt_mem[k], ref_mem[k]);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Target models for the three channels
	//////////////////////////////////////////////////
	initial begin : target_models
		logic                   s_wr   [3];
		logic                   s_rd   [3];
		logic [AVMM_ADDR_W-1:0] s_addr [3];
		logic [AVMM_DATA_W-1:0] s_data [3];
		logic                   s_wq   [3];
		int                     stall  [3];
		int                     lat    [3];
		bit                     pend   [3];
		logic [AVMM_ADDR_W-1:0] raddr  [3];

		for (int n = 0; n < 3; n++) begin
			ch_rdata[n]    = '0;
			ch_rdatavld[n] = 1'b0;
			ch_waitreq[n]  = 1'b0;
			stall[n]       = 0;
			lat[n]         = 0;
			pend[n]        = 1'b0;
		end
		forever begin
			@(negedge s_avmm_clk); // Mid cycle, outputs settled
			for (int n = 0; n < 3; n++) begin
				s_wr[n]   = ch_write[n];
				s_rd[n]   = ch_read[n];
				s_addr[n] = ch_addr[n];
				s_data[n] = ch_wdata[n];
				s_wq[n]   = ch_waitreq[n];
				if ((s_wr[n] || s_rd[n]) && n != active_ch) begin
					$display("Strobe on channel %0d while the active channel is %0d", n, active_ch);
					misc_errs++;
				end
				if ((s_wr[n] || s_rd[n]) && ch_be[n] !== 4'hf)
					log_mismatch($sformatf("s_avmm%0d_byte_en", n), 32'(ch_be[n]), 32'hf);
			end
			// Channels other than the selected one stay quiet during a transfer
			if (active_ch >= 0) begin
				if (s_wr[active_ch] || s_rd[active_ch]) begin
					for (int n = 0; n < 3; n++) begin
						if (n != active_ch && ch_addr[n] !== '0)
							log_mismatch($sformatf("s_avmm%0d_addr", n), 32'(ch_addr[n]), 32'h0);
						if (n != active_ch && ch_be[n] !== '0)
							log_mismatch($sformatf("s_avmm%0d_byte_en", n), 32'(ch_be[n]), 32'h0);
						if (n != active_ch && ch_wdata[n] !== '0)
							log_mismatch($sformatf("s_avmm%0d_wdata", n), ch_wdata[n], 32'h0);
					end
				end
			end
			@(posedge s_avmm_clk);
			#1;
			for (int n = 0; n < 3; n++) begin
				if (s_wr[n] && !s_wq[n]) begin // Accepted on the edge just passed
					tgt_mem[mem_key(n, s_addr[n])] = s_data[n];
					wr_log_ch.push_back(n);
					wr_log_addr.push_back(s_addr[n]);
					wr_log_data.push_back(s_data[n]);
					stall[n] = int'($urandom_range(3, 0)); // Preset for the next write
				end else if (s_wr[n]) begin
					stall[n]--;
				end
				ch_waitreq[n] = (stall[n] != 0);

				if (ch_rdatavld[n]) begin
					ch_rdatavld[n] = 1'b0;
					ch_rdata[n]    = '0;
					pend[n]        = 1'b0;
				end else if (pend[n] || s_rd[n]) begin
					if (!pend[n]) begin
						pend[n]  = 1'b1;
						raddr[n] = s_addr[n];
						lat[n]   = int'($urandom_range(4, 1));
						rd_log_ch.push_back(n);
						rd_log_addr.push_back(s_addr[n]);
					end
					lat[n]--;
					if (lat[n] == 0) begin
						ch_rdatavld[n] = 1'b1;
						ch_rdata[n]    = tgt_read(mem_key(n, raddr[n]));
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	initial begin : stimulus
		logic [31:0]            stat;
		logic [AVMM_ADDR_W-1:0] offset;
		logic [1:0]             sel;
		logic                   rdnwr;
		int                     len;

		host_addr  = '0;
		host_wdata = '0;
		host_write = 1'b0;
		host_read  = 1'b0;
		void'($urandom(32'hb5b7_11ae));

		repeat (6) @(posedge s_avmm_clk); // Reset spans the first 4 edges
		#1;
		for (int n = 0; n < 3; n++) begin
			if (ch_write[n] !== 1'b0)
				log_mismatch($sformatf("s_avmm%0d_write", n), 32'(ch_write[n]), 32'h0);
			if (ch_read[n] !== 1'b0)
				log_mismatch($sformatf("s_avmm%0d_read", n), 32'(ch_read[n]), 32'h0);
		end
		host_rd(REG_STATUS, stat);
		if (stat !== 32'h0)
			log_mismatch("REG_STATUS", stat, 32'h0);

		// Write then read back the same words
		sel    = 2'($urandom_range(3, 0));
		len    = int'($urandom_range(16, 1));
		offset = AVMM_ADDR_W'($urandom_range(127, 0) * 4);
		run_burst(1'b0, len, sel, offset);
		if (!timed_out)
			run_burst(1'b1, len, sel, offset);

		for (int i = 0; i < N_RAND && !timed_out; i++) begin
			rdnwr  = 1'($urandom_range(1, 0));
			sel    = 2'($urandom_range(3, 0));
			len    = int'($urandom_range(16, 1));
			offset = AVMM_ADDR_W'($urandom_range(127, 0) * 4);
			run_burst(rdnwr, len, sel, offset);
		end
		compare_memories();

		$display("Error counts: %0d value mismatches, %0d other failures", val_errs, misc_errs);
		if (val_errs == 0 && misc_errs == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end
endmodule

// File: sim.f
hdl/avb_pkg.sv
hdl/spis_reg_pkg.sv
hdl/spis_avb_bridge.sv
hdl/spis_buf_regs.sv
hdl/spis_avb_top.sv
testbench/tb_clk_gen.sv
testbench/spis_avb_assert.sv
testbench/tb_spis_avb.sv

// File: Makefile
# Verilator build and run of the SPI slave to AVMM bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_spis_avb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/10ps

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "Simulation stopped early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
